/* mole_pkg.sv */
package mole_pkg;

	// display geometry
	// eight scan rows, eight columns per row
	localparam int MATRIX_ROWS = 8;
	localparam int MATRIX_COLS = 8;

	// game board
	// 4x4 holes, each one a 2x2 pixel block
	localparam int HOLE_COUNT = 16;

	// one column byte of a scanned row
	// also the active-low row line vector
	typedef logic [MATRIX_COLS-1:0] row_t;

	// full picture of one colour plane
	// pixel index is row * 8 + column
	// row 0 occupies bits 7:0
	typedef logic [MATRIX_ROWS*MATRIX_COLS-1:0] frame_t;

	// one-hot hole select from the random generator
	// bit i picks hole i
	typedef logic [HOLE_COUNT-1:0] hole_sel_t;

	// mole colour
	// bit 0 lights red, bit 1 lights green
	// both bits set shows yellow, zero shows nothing
	typedef logic [1:0] mole_color_t;

	// width of the miss and hit counters
	// limits up to 1023
	typedef logic [9:0] tick_t;

	// scan FSM state
	// one state per display row, walked in rising order
	typedef enum logic [2:0] {
		row_0 = 3'd0,
		row_1 = 3'd1,
		row_2 = 3'd2,
		row_3 = 3'd3,
		row_4 = 3'd4,
		row_5 = 3'd5,
		row_6 = 3'd6,
		row_7 = 3'd7
	} scan_row_e;

endpackage

/* mole_frame.sv */
`timescale 1ns/100ps

module mole_frame import mole_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  hole_sel_t   hole_sel,
	input  mole_color_t mole_color,
	output frame_t      red_frame,
	output frame_t      green_frame
);

	// number of set bits in the select
	// five bits, so all sixteen set still counts right
	logic [4:0] sel_count;
	// index of the set bit when the select is one-hot
	logic [3:0] hole_idx;
	logic       sel_valid;

	// 2x2 block position on the 4x4 board
	logic [1:0] blk_row;
	logic [1:0] blk_col;

	// pixels covered by the selected block
	frame_t block_mask;

	// next frame contents, colour gated
	frame_t red_next;
	frame_t green_next;

	// count set bits and remember the index of the last one
	// index is only meaningful for a single set bit
	always_comb begin
		sel_count = '0;
		hole_idx  = '0;
		for (int i = 0; i < HOLE_COUNT; i++) begin
			if (hole_sel[i]) begin
				sel_count = sel_count + 5'd1;
				hole_idx  = i[3:0];
			end
		end
	end

	// exactly one hole picked
	assign sel_valid = (sel_count == 5'd1);

	// holes 0..3 sit in the bottom block row (pixel rows 6 and 7)
	// holes 12..15 sit in the top block row (pixel rows 0 and 1)
	assign blk_row = 2'd3 - hole_idx[3:2];
	// column inside the block row runs left to right
	assign blk_col = hole_idx[1:0];

	// a pixel belongs to the block when its row and column
	// halved match the block position
	always_comb begin
		block_mask = '0;
		for (int r = 0; r < MATRIX_ROWS; r++) begin
			for (int c = 0; c < MATRIX_COLS; c++) begin
				if (r[2:1] == blk_row && c[2:1] == blk_col) begin
					block_mask[r*MATRIX_COLS+c] = 1'b1;
				end
			end
		end
	end

	// red plane from colour bit 0, green plane from bit 1
	// everything outside the block stays dark
	assign red_next   = mole_color[0] ? block_mask : '0;
	assign green_next = mole_color[1] ? block_mask : '0;

	// frame registers
	// a zero or multi-bit select keeps the old picture
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			red_frame   <= '0;
			green_frame <= '0;
		end else if (sel_valid) begin
			red_frame   <= red_next;
			green_frame <= green_next;
		end
	end

endmodule

/* matrix_row_scan.sv */
`timescale 1ns/100ps

module matrix_row_scan import mole_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  frame_t red_frame,
	input  frame_t green_frame,
	output row_t   row_n,
	output row_t   red_col,
	output row_t   green_col
);

	// current and next scanned row
	scan_row_e state;
	scan_row_e state_next;

	// state as a plain row number
	logic [2:0] row_idx;

	// active-low line for the current row
	row_t row_sel_n;

	assign row_idx = state;

	// next row, wraps from 7 back to 0
	always_comb begin
		case (state)
			row_0: state_next = row_1;
			row_1: state_next = row_2;
			row_2: state_next = row_3;
			row_3: state_next = row_4;
			row_4: state_next = row_5;
			row_5: state_next = row_6;
			row_6: state_next = row_7;
			row_7: state_next = row_0;
			default: state_next = row_0;
		endcase
	end

	// pull the current row low, keep the others high
	always_comb begin
		for (int r = 0; r < MATRIX_ROWS; r++) begin
			row_sel_n[r] = (row_idx != r[2:0]);
		end
	end

	// scan FSM
	// row line and both column bytes are registered together
	// so they change on the same edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= row_0;
			// row 0 selected but dark
			row_n     <= 8'b1111_1110;
			red_col   <= '0;
			green_col <= '0;
		end else begin
			state     <= state_next;
			row_n     <= row_sel_n;
			// row s lives at bits s*8+7 down to s*8
			red_col   <= red_frame[row_idx*MATRIX_COLS +: MATRIX_COLS];
			green_col <= green_frame[row_idx*MATRIX_COLS +: MATRIX_COLS];
		end
	end

endmodule

/* round_timer.sv */
`timescale 1ns/100ps

module round_timer import mole_pkg::*; #(
	parameter int unsigned ROUND_TICKS = 1000
) (
	input  logic clk,
	input  logic rst,
	input  logic hit,
	output logic new_round
);

	// round length in counter width
	localparam tick_t LIMIT = tick_t'(ROUND_TICKS);

	// cycles spent missing
	tick_t miss_cnt;
	// cycles spent hitting
	tick_t hit_cnt;

	logic miss_done;
	logic hit_done;

	// either counter at its limit ends the round
	assign miss_done = (miss_cnt == LIMIT);
	assign hit_done  = (hit_cnt == LIMIT);

	// only one counter runs at a time
	// the idle one is held at zero so a change of hit
	// starts the other count from scratch
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			miss_cnt <= '0;
			hit_cnt  <= '0;
		end else if (hit) begin
			miss_cnt <= '0;
			// wrap once the limit has been seen
			if (hit_done) begin
				hit_cnt <= '0;
			end else begin
				hit_cnt <= hit_cnt + 1'b1;
			end
		end else begin
			hit_cnt <= '0;
			if (miss_done) begin
				miss_cnt <= '0;
			end else begin
				miss_cnt <= miss_cnt + 1'b1;
			end
		end
	end

	// single-cycle request for a new random hole
	// high in the cycle after a counter sits at the limit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			new_round <= 1'b0;
		end else begin
			new_round <= miss_done || hit_done;
		end
	end

endmodule

/* whack_mole_top.sv */
`timescale 1ns/100ps

module whack_mole_top import mole_pkg::*; #(
	// round length in clock cycles, passed to the timer
	parameter int unsigned ROUND_TICKS = 1000
) (
	input  logic        clk,
	input  logic        rst,
	// mole position and colour from the random generator
	input  hole_sel_t   hole_sel,
	input  mole_color_t mole_color,
	// key matched the lit hole
	input  logic        hit,
	// matrix drive
	output row_t        row_n,
	output row_t        red_col,
	output row_t        green_col,
	// request for the next mole
	output logic        new_round
);

	// colour planes between frame builder and scanner
	frame_t red_frame;
	frame_t green_frame;

	// picture of the current mole
	mole_frame u_mole_frame (
		.clk         (clk),
		.rst         (rst),
		.hole_sel    (hole_sel),
		.mole_color  (mole_color),
		.red_frame   (red_frame),
		.green_frame (green_frame)
	);

	// free running row scan of both planes
	matrix_row_scan u_matrix_row_scan (
		.clk         (clk),
		.rst         (rst),
		.red_frame   (red_frame),
		.green_frame (green_frame),
		.row_n       (row_n),
		.red_col     (red_col),
		.green_col   (green_col)
	);

	// round length tracking
	// independent of what is on the display
	round_timer #(
		.ROUND_TICKS (ROUND_TICKS)
	) u_round_timer (
		.clk       (clk),
		.rst       (rst),
		.hit       (hit),
		.new_round (new_round)
	);

endmodule

/* whack_mole_chk.sv */
`timescale 1ns/100ps

module whack_mole_chk import mole_pkg::*; (
	input logic   clk,
	input logic   rst,
	input frame_t red_frame,
	input frame_t green_frame,
	input row_t   row_n,
	input row_t   red_col,
	input row_t   green_col,
	input logic   new_round
);

	// exactly one row line pulled low, reset value included
	a_one_row_active: assert property (
		@(posedge clk) $onehot(~row_n)
	) else $error("row_n does not have exactly one active row");

	// new_round is a single-cycle request
	a_pulse_single: assert property (
		@(posedge clk) disable iff (rst)
		new_round |=> !new_round
	) else $error("new_round high for two cycles in a row");

	// a dark plane gives a dark column byte one clock later
	// whatever row is scanned
	a_red_dark: assert property (
		@(posedge clk) disable iff (rst)
		(red_frame == '0) |=> (red_col == '0)
	) else $error("red column lit while the red frame is empty");

	a_green_dark: assert property (
		@(posedge clk) disable iff (rst)
		(green_frame == '0) |=> (green_col == '0)
	) else $error("green column lit while the green frame is empty");

endmodule

// frames are internal to the top level, reached by name
bind whack_mole_top whack_mole_chk u_chk (
	.clk         (clk),
	.rst         (rst),
	.red_frame   (red_frame),
	.green_frame (green_frame),
	.row_n       (row_n),
	.red_col     (red_col),
	.green_col   (green_col),
	.new_round   (new_round)
);

/* whack_mole_tb.sv */
`timescale 1ns/100ps

module whack_mole_tb import mole_pkg::*; ();

	localparam int ROUND_TICKS = 20;
	localparam int CLK_PERIOD  = 40;
	// cycles per displayed mole: settle plus one full scan checked
	localparam int MOLE_CYCLES = 28;
	localparam int MOLE_COUNT  = 16 + 12 + 4;
	localparam int TEST_CYCLES = 5 + MOLE_COUNT * MOLE_CYCLES + 300;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

	logic        clk;
	logic        rst;
	hole_sel_t   hole_sel;
	mole_color_t mole_color;
	logic        hit;
	row_t        row_n;
	row_t        red_col;
	row_t        green_col;
	logic        new_round;

	// expected picture, kept by the stimulus
	frame_t exp_red;
	frame_t exp_green;
	logic   check_en;

	int errors;
	int checks;

	// compare process state
	int sample_k;
	int row_idx;
	int prev_idx;
	// samples since reset release, a hit change or the last pulse
	int gap;
	logic hit_prev;
	int pulse_count;

	int          n0;
	logic [31:0] rnd;

	whack_mole_top #(
		.ROUND_TICKS (ROUND_TICKS)
	) DUT (
		.clk        (clk),
		.rst        (rst),
		.hole_sel   (hole_sel),
		.mole_color (mole_color),
		.hit        (hit),
		.row_n      (row_n),
		.red_col    (red_col),
		.green_col  (green_col),
		.new_round  (new_round)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int count_ones(input hole_sel_t s);
		int n;
		n = 0;
		for (int i = 0; i < HOLE_COUNT; i++) begin
			n += s[i];
		end
		return n;
	endfunction

	// one colour plane of the mole picture
	// hole i: block row 3 - i/4, block column i%4, 2x2 pixels each
	function automatic frame_t ref_frame(input hole_sel_t s, input logic lit);
		frame_t f;
		int br;
		int bc;
		f = '0;
		for (int i = 0; i < HOLE_COUNT; i++) begin
			if (s[i]) begin
				br = 3 - i / 4;
				bc = i % 4;
				for (int dr = 0; dr < 2; dr++) begin
					for (int dc = 0; dc < 2; dc++) begin
						f[(2 * br + dr) * MATRIX_COLS + 2 * bc + dc] = lit;
					end
				end
			end
		end
		return f;
	endfunction

	// column byte of pixel row r, index row * 8 + column
	function automatic row_t row_byte(input frame_t f, input int r);
		row_t b;
		for (int c = 0; c < MATRIX_COLS; c++) begin
			b[c] = f[r * MATRIX_COLS + c];
		end
		return b;
	endfunction

	// lowest row pulled low
	function automatic int zero_pos(input row_t rn);
		int p;
		p = 0;
		for (int r = MATRIX_ROWS - 1; r >= 0; r--) begin
			if (!rn[r]) p = r;
		end
		return p;
	endfunction

	function automatic int count_zeros(input row_t rn);
		int n;
		n = 0;
		for (int r = 0; r < MATRIX_ROWS; r++) begin
			n += !rn[r];
		end
		return n;
	endfunction

	// outputs are read at the rising edge, before the DUT updates them
	always @(posedge clk) begin
		if (rst) begin
			check_value(row_n, 8'hfe, "row_n in reset");
			check_value({red_col, green_col}, 16'h0, "columns in reset");
			check_value(new_round, 1'b0, "new_round in reset");
			sample_k = 0;
			gap      = 0;
			hit_prev = hit;
		end else begin
			sample_k++;
			row_idx = zero_pos(row_n);
			if (sample_k == 1) begin
				check_value(row_n, 8'hfe, "row_n after reset");
				check_value({red_col, green_col}, 16'h0, "columns after reset");
			end
			check_value(count_zeros(row_n), 1, "active rows in row_n");
			// row 0 shows twice after reset, then one step per cycle
			if (sample_k >= 3) begin
				check_value(row_idx, (prev_idx + 1) % MATRIX_ROWS, "scan row order");
			end
			prev_idx = row_idx;
			if (check_en) begin
				check_value(red_col, row_byte(exp_red, row_idx), "red column");
				check_value(green_col, row_byte(exp_green, row_idx), "green column");
			end
			// pulse is registered after the count reaches the limit
			// so it shows on sample ROUND_TICKS + 2 of a period
			if (hit !== hit_prev) begin
				gap = 1;
			end else begin
				gap = gap + 1;
			end
			hit_prev = hit;
			check_value(new_round, gap == ROUND_TICKS + 2, "new_round");
			if (new_round) pulse_count++;
			if (gap == ROUND_TICKS + 2) gap = 1;
		end
	end

	// hold a select, let it settle, then check one whole scan
	task automatic show_mole(input hole_sel_t s, input mole_color_t color);
		hole_sel   = s;
		mole_color = color;
		// invalid selects keep the old picture
		if (count_ones(s) == 1) begin
			exp_red   = ref_frame(s, color[0]);
			exp_green = ref_frame(s, color[1]);
		end
		repeat (MOLE_CYCLES - 8) @(negedge clk);
		check_en = 1'b1;
		repeat (8) @(negedge clk);
		check_en = 1'b0;
	endtask

	task automatic wait_gap(input int g);
		while (gap != g) @(negedge clk);
	endtask

	initial begin
		rst         = 1'b1;
		hole_sel    = '0;
		mole_color  = '0;
		hit         = 1'b0;
		check_en    = 1'b0;
		exp_red     = '0;
		exp_green   = '0;
		errors      = 0;
		checks      = 0;
		pulse_count = 0;
		prev_idx    = 0;
		rnd         = 32'd96;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// every hole in yellow
		for (int i = 0; i < HOLE_COUNT; i++) begin
			show_mole(hole_sel_t'(1) << i, 2'b11);
		end

		// random holes, colour cycles red, green, yellow, off
		for (int k = 0; k < 12; k++) begin
			rnd = lcg_next(rnd);
			show_mole(hole_sel_t'(1) << rnd[19:16], mole_color_t'((k + 1) % 4));
		end

		// zero and multi-bit selects leave the picture alone
		show_mole(16'h0020, 2'b11);
		show_mole(16'h0000, 2'b01);
		show_mole(16'h0101, 2'b10);
		show_mole(16'hffff, 2'b01);

		// hit low: three pulses in any 63 cycles
		wait_gap(3);
		n0 = pulse_count;
		repeat (63) @(negedge clk);
		check_value(pulse_count - n0, 3, "pulses with hit low");

		// hit high: pulses at 21, 42, 63 cycles after the change
		wait_gap(5);
		hit = 1'b1;
		n0  = pulse_count;
		repeat (84) @(negedge clk);
		check_value(pulse_count - n0, 3, "pulses with hit high");

		// toggles before the limit restart the count
		wait_gap(10);
		n0  = pulse_count;
		hit = 1'b0;
		repeat (12) @(negedge clk);
		hit = 1'b1;
		repeat (12) @(negedge clk);
		hit = 1'b0;
		repeat (21) @(negedge clk);
		check_value(pulse_count - n0, 0, "pulses before restarted round ends");
		@(negedge clk);
		check_value(pulse_count - n0, 1, "pulse after restarted round");

		repeat (2) @(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* project.f */
mole_pkg.sv
mole_frame.sv
matrix_row_scan.sv
round_timer.sv
whack_mole_top.sv
whack_mole_chk.sv
whack_mole_tb.sv
